/* decodeStage.sv */
/*
 Decode, register file and RAW interlock. No forwarding. A source that
 matches a pending rd in any later register stalls decode.
 Write-back is visible to a read in the same cycle. Unknown opcodes drop out.
*/
`timescale 1ns/1ps
`default_nettype none
`include "rvPipe_config.svh"

module decodeStage (
    input  wire logic                      clk,
    input  wire logic                      reset_n,
    input  wire rvPipePkg::fetchToDecode   fromFetch,
    input  wire logic                      hold,
    input  wire rvPipePkg::executeToMemory exDest,
    input  wire rvPipePkg::executeToMemory memDest,
    input  wire rvPipePkg::writeBack       wb,
    output logic                           stall,
    output rvPipePkg::decodeToExecute      toExecute
);

    rvPipePkg::xlenWord regFile [`RV_REG_COUNT]; // Slot 0 never read
    rvPipePkg::regIndex rs1, rs2, rd;
    rvPipePkg::xlenWord rs1Val, rs2Val, immI, immS, immU;
    rvPipePkg::decodeToExecute decoded;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic useRs1, useRs2, rs1Busy, rs2Busy, interlock;

    function automatic rvPipePkg::aluOp opFromFunct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rvPipePkg::ALU_SUB : rvPipePkg::ALU_ADD;
            3'b001:  return rvPipePkg::ALU_SLL;
            3'b010:  return rvPipePkg::ALU_SLT;
            3'b011:  return rvPipePkg::ALU_SLTU;
            3'b100:  return rvPipePkg::ALU_XOR;
            3'b101:  return alt ? rvPipePkg::ALU_SRA : rvPipePkg::ALU_SRL;
            3'b110:  return rvPipePkg::ALU_OR;
            default: return rvPipePkg::ALU_AND;
        endcase
    endfunction

    // Source waits on a valid, register-writing entry with the same rd
    function automatic logic waitsOn(input rvPipePkg::regIndex src, input logic valid,
                                     input logic regWrite, input rvPipePkg::regIndex dst);
        return valid && regWrite && (src == dst);
    endfunction

    assign opcode = fromFetch.instr[6:0];
    assign funct3 = fromFetch.instr[14:12];
    assign rd     = fromFetch.instr[11:7];
    assign rs1    = fromFetch.instr[19:15];
    assign rs2    = fromFetch.instr[24:20];
    assign immI   = {{20{fromFetch.instr[31]}}, fromFetch.instr[31:20]};
    assign immS   = {{20{fromFetch.instr[31]}}, fromFetch.instr[31:25], fromFetch.instr[11:7]};
    assign immU   = {fromFetch.instr[31:12], 12'b0};

    // Reads with write-back bypass
    assign rs1Val = (rs1 == '0) ? '0 : (wb.valid && wb.rd == rs1) ? wb.value : regFile[rs1];
    assign rs2Val = (rs2 == '0) ? '0 : (wb.valid && wb.rd == rs2) ? wb.value : regFile[rs2];

    always_comb begin
        decoded           = '0;
        decoded.operandA  = rs1Val;
        decoded.storeData = rs2Val;
        decoded.rd        = rd;
        useRs1            = 1'b1;
        useRs2            = 1'b0;
        case (opcode)
            7'b0110011: begin                    // Register-register
                decoded.valid    = 1'b1;
                decoded.regWrite = 1'b1;
                decoded.operandB = rs2Val;
                decoded.op       = opFromFunct(funct3, fromFetch.instr[30]);
                useRs2           = 1'b1;
            end
            7'b0010011: begin                    // Immediate forms without SUBI
                decoded.valid    = 1'b1;
                decoded.regWrite = 1'b1;
                decoded.operandB = immI;
                decoded.op       = opFromFunct(funct3, funct3 == 3'b101 && fromFetch.instr[30]);
            end
            7'b0110111: begin                    // LUI
                decoded.valid    = 1'b1;
                decoded.regWrite = 1'b1;
                decoded.operandB = immU;
                decoded.op       = rvPipePkg::ALU_PASS_B;
                useRs1           = 1'b0;
            end
            7'b0000011: begin                    // LW
                decoded.valid    = 1'b1;
                decoded.regWrite = 1'b1;
                decoded.isLoad   = 1'b1;
                decoded.operandB = immI;
            end
            7'b0100011: begin                    // SW
                decoded.valid    = 1'b1;
                decoded.isStore  = 1'b1;
                decoded.operandB = immS;
                useRs2           = 1'b1;
            end
            default: useRs1 = 1'b0;              // Unsupported
        endcase
        decoded.regWrite = decoded.regWrite && (rd != '0);
        decoded.valid    = decoded.valid && fromFetch.valid;
    end

    assign rs1Busy = waitsOn(rs1, toExecute.valid, toExecute.regWrite, toExecute.rd)
                  || waitsOn(rs1, exDest.valid, exDest.regWrite, exDest.rd)
                  || waitsOn(rs1, memDest.valid, memDest.regWrite, memDest.rd);
    assign rs2Busy = waitsOn(rs2, toExecute.valid, toExecute.regWrite, toExecute.rd)
                  || waitsOn(rs2, exDest.valid, exDest.regWrite, exDest.rd)
                  || waitsOn(rs2, memDest.valid, memDest.regWrite, memDest.rd);
    assign interlock = fromFetch.valid && ((useRs1 && rs1Busy) || (useRs2 && rs2Busy));
    assign stall     = interlock || hold;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++)
                regFile[i] <= '0;
        end else if (wb.valid && wb.rd != '0) begin
            regFile[wb.rd] <= wb.value;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            toExecute <= '0;
        else if (hold)
            toExecute <= toExecute;              // Memory stage busy
        else if (interlock)
            toExecute <= '0;                     // Bubble
        else
            toExecute <= decoded;
    end

    // Retirement never targets x0
    assert property (@(posedge clk) disable iff (!reset_n) wb.valid |-> wb.rd != '0);

endmodule

`default_nettype wire

/* executeStage.sv */
/*
 ALU and execute/memory register. The register freezes while hold is high.
 Shift amounts use the low 5 bits of operand B.
*/
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire logic                      clk,
    input  wire logic                      reset_n,
    input  wire rvPipePkg::decodeToExecute fromDecode,
    input  wire logic                      hold,
    output rvPipePkg::executeToMemory      toMemory
);

    rvPipePkg::xlenWord a, b, result;

    assign a = fromDecode.operandA;
    assign b = fromDecode.operandB;

    always_comb begin
        case (fromDecode.op)
            rvPipePkg::ALU_ADD:    result = a + b;
            rvPipePkg::ALU_SUB:    result = a - b;
            rvPipePkg::ALU_AND:    result = a & b;
            rvPipePkg::ALU_OR:     result = a | b;
            rvPipePkg::ALU_XOR:    result = a ^ b;
            rvPipePkg::ALU_SLL:    result = a << b[4:0];
            rvPipePkg::ALU_SRL:    result = a >> b[4:0];
            rvPipePkg::ALU_SRA:    result = $unsigned($signed(a) >>> b[4:0]);
            rvPipePkg::ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            rvPipePkg::ALU_SLTU:   result = {31'b0, a < b};
            rvPipePkg::ALU_PASS_B: result = b;    // LUI
            default:               result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            toMemory <= '0;
        end else if (!hold) begin
            if (fromDecode.valid) begin
                toMemory.valid     <= 1'b1;
                toMemory.aluResult <= result;
                toMemory.storeData <= fromDecode.storeData;
                toMemory.rd        <= fromDecode.rd;
                toMemory.regWrite  <= fromDecode.regWrite;
                toMemory.isLoad    <= fromDecode.isLoad;
                toMemory.isStore   <= fromDecode.isStore;
            end else begin
                toMemory <= '0;                   // Pass the bubble on
            end
        end
    end

endmodule

`default_nettype wire

/* fetchStage.sv */
/*
 One fetch outstanding at a time. A request starts only once the output
 register is empty or being consumed, so a returning word always has room.
*/
`timescale 1ns/1ps
`default_nettype none
`include "rvPipe_config.svh"

module fetchStage (
    input  wire logic                    clk,
    input  wire logic                    reset_n,
    input  wire logic                    stall,
    input  wire rvPipePkg::memResponse   memResp,
    output rvPipePkg::memRequest         memReq,
    output rvPipePkg::fetchToDecode      toDecode
);

    rvPipePkg::xlenWord pc;
    logic reqActive;                     // Read in flight at pc

    assign memReq.valid = reqActive;
    assign memReq.write = 1'b0;          // Fetch only reads
    assign memReq.addr  = pc;
    assign memReq.wdata = '0;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc             <= `RV_RESET_PC;
            reqActive      <= 1'b0;
            toDecode.valid <= 1'b0;
            toDecode.pc    <= `RV_RESET_PC;
            toDecode.instr <= `RV_NOP;
        end else begin
            if (toDecode.valid && !stall)
                toDecode.valid <= 1'b0;  // Consumed by decode
            if (memResp.done) begin
                toDecode.valid <= 1'b1;
                toDecode.pc    <= pc;
                toDecode.instr <= memResp.rdata;
                pc             <= pc + 32'd4;
                reqActive      <= 1'b0;
            end else if (!reqActive && (!toDecode.valid || !stall)) begin
                reqActive <= 1'b1;       // Register empties at this edge
            end
        end
    end

endmodule

`default_nettype wire

/* memArbiter.sv */
/*
 Single AXI4-Lite master shared by data and fetch, one transaction at a time.
 Data wins in IDLE. No new grant on the done cycle, while the requester still
 shows its old request. Response codes are not checked.
*/
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
    input  wire logic                    clk,
    input  wire logic                    reset_n,
    input  wire rvPipePkg::memRequest    dataReq,
    input  wire rvPipePkg::memRequest    fetchReq,
    output rvPipePkg::memResponse        dataResp,
    output rvPipePkg::memResponse        fetchResp,
    output logic                         arValid,
    input  wire logic                    arReady,
    output rvPipePkg::xlenWord           arAddr,
    input  wire logic                    rValid,
    output logic                         rReady,
    input  wire rvPipePkg::xlenWord      rData,
    input  wire logic [1:0]              rResp,
    output logic                         awValid,
    input  wire logic                    awReady,
    output rvPipePkg::xlenWord           awAddr,
    output logic                         wValid,
    input  wire logic                    wReady,
    output rvPipePkg::xlenWord           wData,
    output logic [`RV_XLEN/8-1:0]        wStrb,
    input  wire logic                    bValid,
    output logic                         bReady,
    input  wire logic [1:0]              bResp
);

    rvPipePkg::arbState   state;
    rvPipePkg::memRequest pick;
    rvPipePkg::xlenWord   rdataReg;
    logic grantData, doneReg, start;

    assign pick  = dataReq.valid ? dataReq : fetchReq; // Data first
    assign start = (state == rvPipePkg::IDLE) && !doneReg && pick.valid;

    assign rReady = (state == rvPipePkg::READ_DATA);
    assign bReady = (state == rvPipePkg::WRITE_RESP);
    assign wStrb  = '1;                                 // Word writes only

    assign dataResp.done   = doneReg && grantData;
    assign dataResp.rdata  = rdataReg;
    assign fetchResp.done  = doneReg && !grantData;
    assign fetchResp.rdata = rdataReg;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= rvPipePkg::IDLE;
            grantData <= 1'b0;
            doneReg   <= 1'b0;
            arValid   <= 1'b0;
            awValid   <= 1'b0;
            wValid    <= 1'b0;
        end else begin
            doneReg <= 1'b0;
            case (state)
                rvPipePkg::IDLE: if (start) begin
                    grantData <= dataReq.valid;
                    if (pick.write) begin
                        awValid <= 1'b1;                // AW and W together
                        wValid  <= 1'b1;
                        state   <= rvPipePkg::WRITE_REQ;
                    end else begin
                        arValid <= 1'b1;
                        state   <= rvPipePkg::READ_ADDR;
                    end
                end
                rvPipePkg::READ_ADDR: if (arReady) begin
                    arValid <= 1'b0;
                    state   <= rvPipePkg::READ_DATA;
                end
                rvPipePkg::READ_DATA: if (rValid) begin
                    doneReg <= 1'b1;
                    state   <= rvPipePkg::IDLE;
                end
                rvPipePkg::WRITE_REQ: begin
                    if (awReady) awValid <= 1'b0;
                    if (wReady)  wValid  <= 1'b0;
                    if ((!awValid || awReady) && (!wValid || wReady))
                        state <= rvPipePkg::WRITE_RESP;
                end
                rvPipePkg::WRITE_RESP: if (bValid) begin
                    doneReg <= 1'b1;
                    state   <= rvPipePkg::IDLE;
                end
                default: state <= rvPipePkg::IDLE;
            endcase
        end
    end

    // Payload loaded once per transaction
    always_ff @(posedge clk) begin
        if (start) begin
            arAddr <= pick.addr;
            awAddr <= pick.addr;
            wData  <= pick.wdata;
        end
        if (rValid && rReady)
            rdataReg <= rData;
    end

    // Done goes back only to a requester still holding its request
    assert property (@(posedge clk) disable iff (!reset_n)
        doneReg |-> (grantData ? dataReq.valid : fetchReq.valid));
    // AR address follows the granted request while it waits for arReady
    assert property (@(posedge clk) disable iff (!reset_n)
        arValid |-> arAddr == (grantData ? dataReq.addr : fetchReq.addr));

endmodule

`default_nettype wire

/* memoryStage.sv */
/*
 Holds one instruction. ALU results retire the cycle after arrival.
 LW/SW keep busy high until the arbiter returns done; a load retires then.
*/
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
    input  wire logic                      clk,
    input  wire logic                      reset_n,
    input  wire rvPipePkg::executeToMemory fromExecute,
    input  wire rvPipePkg::memResponse     memResp,
    output rvPipePkg::memRequest           memReq,
    output logic                           busy,
    output rvPipePkg::executeToMemory      current,
    output rvPipePkg::writeBack            wb
);

    logic isMem;                                    // Load or store in hand

    assign isMem = current.valid && (current.isLoad || current.isStore);
    assign busy  = isMem && !memResp.done;

    assign memReq.valid = isMem;
    assign memReq.write = current.isStore;
    assign memReq.addr  = current.aluResult;
    assign memReq.wdata = current.storeData;

    assign wb.valid = current.valid && current.regWrite && (!isMem || memResp.done);
    assign wb.rd    = current.rd;
    assign wb.value = current.isLoad ? memResp.rdata : current.aluResult;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            current <= '0;
        else if (!busy)
            current <= fromExecute;                 // Takes bubbles too
    end

    // Done only answers a request this stage still holds
    assert property (@(posedge clk) disable iff (!reset_n)
        memResp.done |-> isMem);

endmodule

`default_nettype wire

/* runSim.sh */
#!/bin/sh
# Build with Verilator, run, then decide pass or fail from the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module rvPipeTopTb -f rvPipeTop.f \
    -o rvPipeSim > build.log 2>&1 &&
./obj_dir/rvPipeSim > sim.log 2>&1 ||
{ echo "Build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

/* rvPipePkg.sv */
/*
 Shared types of the pipeline. Stage registers are packed structs.
 Field widths follow the macros in the config header.
*/
`default_nettype none
`include "rvPipe_config.svh"

package rvPipePkg;

    typedef logic [`RV_XLEN-1:0] xlenWord;              // Data or address word
    typedef logic [31:0] instrWord;                     // Raw instruction
    typedef logic [$clog2(`RV_REG_COUNT)-1:0] regIndex; // Register number

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_PASS_B                                      // LUI result
    } aluOp;

    typedef struct packed {
        logic     valid;
        xlenWord  pc;
        instrWord instr;
    } fetchToDecode;

    typedef struct packed {
        logic    valid;
        xlenWord operandA;
        xlenWord operandB;                              // Register or immediate
        xlenWord storeData;                             // rs2 value for SW
        regIndex rd;
        logic    regWrite;
        logic    isLoad;
        logic    isStore;
        aluOp    op;
    } decodeToExecute;

    typedef struct packed {
        logic    valid;
        xlenWord aluResult;                             // Result or address
        xlenWord storeData;
        regIndex rd;
        logic    regWrite;
        logic    isLoad;
        logic    isStore;
    } executeToMemory;

    typedef struct packed {
        logic    valid;
        regIndex rd;
        xlenWord value;
    } writeBack;

    typedef struct packed {
        logic    valid;
        logic    write;
        xlenWord addr;
        xlenWord wdata;
    } memRequest;

    typedef struct packed {
        logic    done;                                  // One cycle per transaction
        xlenWord rdata;
    } memResponse;

    typedef enum logic [2:0] {
        IDLE, READ_ADDR, READ_DATA, WRITE_REQ, WRITE_RESP
    } arbState;

endpackage

`default_nettype wire

/* rvPipeTop.f */
+incdir+.
rvPipePkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
memArbiter.sv
rvPipeTop.sv
rvPipeTopTb.sv

/* rvPipeTop.sv */
/*
 Four-stage RV32I subset core on one AXI4-Lite master port.
 Memory-stage busy freezes execute, decode and fetch.
*/
`timescale 1ns/1ps
`default_nettype none
`include "rvPipe_config.svh"

module rvPipeTop (
    input  wire logic                clk,
    input  wire logic                reset_n,
    output logic                     arValid,
    input  wire logic                arReady,
    output rvPipePkg::xlenWord       arAddr,
    input  wire logic                rValid,
    output logic                     rReady,
    input  wire rvPipePkg::xlenWord  rData,
    input  wire logic [1:0]          rResp,
    output logic                     awValid,
    input  wire logic                awReady,
    output rvPipePkg::xlenWord       awAddr,
    output logic                     wValid,
    input  wire logic                wReady,
    output rvPipePkg::xlenWord       wData,
    output logic [`RV_XLEN/8-1:0]    wStrb,
    input  wire logic                bValid,
    output logic                     bReady,
    input  wire logic [1:0]          bResp
);

    rvPipePkg::fetchToDecode   f2d;
    rvPipePkg::decodeToExecute d2e;
    rvPipePkg::executeToMemory e2m, memCurrent;
    rvPipePkg::writeBack       wbBus;
    rvPipePkg::memRequest      fetchReq, dataReq;
    rvPipePkg::memResponse     fetchResp, dataResp;
    logic decodeStall, memBusy;

    fetchStage fetch_inst (
        .clk(clk), .reset_n(reset_n), .stall(decodeStall),
        .memResp(fetchResp), .memReq(fetchReq), .toDecode(f2d)
    );

    decodeStage decode_inst (
        .clk(clk), .reset_n(reset_n), .fromFetch(f2d), .hold(memBusy),
        .exDest(e2m), .memDest(memCurrent), .wb(wbBus),
        .stall(decodeStall), .toExecute(d2e)
    );

    executeStage execute_inst (
        .clk(clk), .reset_n(reset_n), .fromDecode(d2e), .hold(memBusy),
        .toMemory(e2m)
    );

    memoryStage memory_inst (
        .clk(clk), .reset_n(reset_n), .fromExecute(e2m), .memResp(dataResp),
        .memReq(dataReq), .busy(memBusy), .current(memCurrent), .wb(wbBus)
    );

    memArbiter arbiter_inst (
        .clk(clk), .reset_n(reset_n),
        .dataReq(dataReq), .fetchReq(fetchReq),
        .dataResp(dataResp), .fetchResp(fetchResp),
        .arValid(arValid), .arReady(arReady), .arAddr(arAddr),
        .rValid(rValid), .rReady(rReady), .rData(rData), .rResp(rResp),
        .awValid(awValid), .awReady(awReady), .awAddr(awAddr),
        .wValid(wValid), .wReady(wReady), .wData(wData), .wStrb(wStrb),
        .bValid(bValid), .bReady(bReady), .bResp(bResp)
    );

endmodule

`default_nettype wire

/* rvPipeTopTb.sv */
/*
 Random and directed programs run on the core against a sequential model.
 Memory is 4 KB, word addressed, with random ready/valid delays.
 Program at 0x000, result area at 0x400, 64-word data area at 0x700.
*/
`timescale 1ns/1ps
`default_nettype none
`include "rvPipe_config.svh"

module rvPipeTopTb;

    localparam int PROG_LEN  = 75;                 // 60 random plus 15 closing stores
    localparam int NUM_TESTS = 4;

    logic clk = 1'b0;
    logic reset_n = 1'b0;
    logic arReady = 1'b0, rValid = 1'b0, awReady = 1'b0, wReady = 1'b0, bValid = 1'b0;
    logic arValid, rReady, awValid, wValid, bReady;
    logic [31:0] rData = '0;
    logic [31:0] arAddr, awAddr, wData;
    logic [3:0]  wStrb;
    logic [1:0]  rResp = 2'b00, bResp = 2'b00;     // Always OKAY

    logic [31:0] mem [1024];                       // Memory behind the AXI port
    logic [31:0] prog [PROG_LEN];
    logic [31:0] mReg [32];                        // Model register file
    logic [31:0] mData [1024];                     // Model data memory
    logic [63:0] expStores[$], gotStores[$];       // {addr, data}
    integer seed = 73;
    int maxDelay = 3;
    int errors = 0, failedTests = 0;
    logic rPend = 1'b0, awGot = 1'b0, wGot = 1'b0, firstArSeen = 1'b0;
    logic [31:0] rAddr, wAddrHold, wDataHold;
    logic [31:0] firstAr = '1;
    logic [3:0]  strbAll = '1;                     // AND of every write strobe

    rvPipeTop rvPipeTop_inst (.*);

    initial begin
        forever #4 clk = ~clk;                     // 8 ns period
    end

    function automatic logic [31:0] fillWord(input int unsigned addr);
        return addr * 32'h9E37_79B9 + 32'h1357_2468;
    endfunction

    function logic [31:0] memInit(input int i);
        if (i < PROG_LEN) return prog[i];
        if (i >= 448 && i < 512) return fillWord(i); // Data area
        return `RV_NOP;
    endfunction

    function logic chance();                       // Ready or valid comes up this cycle
        return ($unsigned($random(seed)) % (maxDelay + 1)) == 0;
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] off, input logic [4:0] rs2);
        return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011}; // SW rs2, off(x0)
    endfunction

    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task addClosing();
        for (int r = 1; r < 16; r++)
            prog[59 + r] = encS(12'h400 + 12'(4 * r - 4), 5'(r));
    endtask

    task genRandom();
        logic [31:0] w;
        logic [4:0] rd, rs1, rs2;
        logic [2:0] f3;
        logic [11:0] imm;
        for (int i = 0; i < 60; i++) begin
            w = $random(seed);
            rd = {1'b0, w[3:0]};                   // x0..x15 only
            rs1 = {1'b0, w[7:4]};
            rs2 = {1'b0, w[11:8]};
            f3 = w[14:12];
            imm = w[26:15];
            case (w[30:28])
                3'd0, 3'd1: prog[i] = encR((f3 == 3'd0 || f3 == 3'd5) && w[27] ? 7'h20 : 7'h00,
                                           rs2, rs1, f3, rd);
                3'd4: prog[i] = {w[27:8], rd, 7'b0110111};                   // LUI
                3'd5: prog[i] = encI({4'b0111, w[20:15], 2'b00}, 5'd0, 3'b010, rd, 7'b0000011);
                3'd6: prog[i] = encS({4'b0111, w[20:15], 2'b00}, rs2);
                default: begin
                    if (f3 == 3'd1) imm = {7'h00, imm[4:0]};              // SLLI
                    if (f3 == 3'd5) imm = {1'b0, w[27], 5'b0, imm[4:0]};   // SRLI or SRAI
                    prog[i] = encI(imm, rs1, f3, rd, 7'b0010011);
                end
            endcase
        end
        addClosing();
    endtask

    // Back-to-back dependencies and load-use
    task genHazards();
        for (int i = 0; i < 60; i++) prog[i] = `RV_NOP;
        prog[0]  = {20'h12345, 5'd1, 7'b0110111};                    // LUI x1
        prog[1]  = encI(12'h678, 5'd1, 3'b000, 5'd2, 7'b0010011);     // ADDI x2,x1
        prog[2]  = encR(7'h20, 5'd1, 5'd2, 3'b000, 5'd3);             // SUB x3,x2,x1
        prog[3]  = encS(12'h704, 5'd3);
        prog[4]  = encI(12'h704, 5'd0, 3'b010, 5'd4, 7'b0000011);     // LW x4
        prog[5]  = encR(7'h00, 5'd4, 5'd4, 3'b000, 5'd5);             // Load-use
        prog[6]  = encR(7'h00, 5'd5, 5'd5, 3'b001, 5'd6);             // SLL x6,x5,x5
        prog[7]  = encI(12'hFFF, 5'd6, 3'b100, 5'd6, 7'b0010011);     // XORI x6,x6,-1
        prog[8]  = encS(12'h708, 5'd6);
        prog[9]  = encI(12'h708, 5'd0, 3'b010, 5'd7, 7'b0000011);     // LW x7
        prog[10] = encS(12'h70C, 5'd7);                               // Store right after load
        prog[11] = encR(7'h00, 5'd7, 5'd1, 3'b011, 5'd8);             // SLTU x8
        prog[12] = encR(7'h20, 5'd8, 5'd7, 3'b101, 5'd9);             // SRA x9
        prog[13] = encI(12'h005, 5'd9, 3'b000, 5'd0, 7'b0010011);     // Write to x0
        addClosing();
    endtask

    // Sequential execution of prog one instruction at a time
    task runModel();
        logic [31:0] ins, a, b, immI, addr, res;
        expStores.delete();
        for (int i = 0; i < 32; i++) mReg[i] = '0;
        for (int i = 0; i < 1024; i++) mData[i] = fillWord(i);
        for (int i = 0; i < PROG_LEN; i++) begin
            ins = prog[i];
            a = mReg[ins[19:15]];
            b = mReg[ins[24:20]];
            immI = {{20{ins[31]}}, ins[31:20]};
            res = '0;
            case (ins[6:0])
                7'b0110011: res = aluModel(ins[14:12], ins[30], a, b);
                7'b0010011: res = aluModel(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, immI);
                7'b0110111: res = {ins[31:12], 12'b0};
                7'b0000011: begin
                    addr = a + immI;
                    res = mData[addr[11:2]];
                end
                7'b0100011: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    mData[addr[11:2]] = b;                                // Data from rs2
                    expStores.push_back({addr, b});
                end
                default: res = '0;
            endcase
            if (ins[6:0] != 7'b0100011 && ins[11:7] != 5'd0) mReg[ins[11:7]] = res;
        end
    endtask

    // AXI4-Lite slave with random delays; records every write in order
    always @(posedge clk) begin
        if (!reset_n) begin
            {arReady, rValid, awReady, wReady, bValid} <= '0;
            {rPend, awGot, wGot, firstArSeen} <= '0;
            strbAll <= '1;
            for (int i = 0; i < 1024; i++) mem[i] <= memInit(i);
            gotStores.delete();
        end else begin
            if (arValid && arReady) begin
                arReady <= 1'b0;
                rPend <= 1'b1;
                rAddr <= arAddr;
                firstArSeen <= 1'b1;
                if (!firstArSeen) firstAr <= arAddr;
            end else if (arValid && !rPend) begin
                arReady <= chance();
            end
            if (rValid && rReady) begin
                rValid <= 1'b0;
                rPend <= 1'b0;
            end else if (rPend && !rValid && chance()) begin
                rValid <= 1'b1;
                rData <= mem[rAddr[11:2]];
            end
            if (awValid && awReady) begin
                awReady <= 1'b0;
                awGot <= 1'b1;
                wAddrHold <= awAddr;
            end else if (awValid && !awGot) begin
                awReady <= chance();
            end
            if (wValid && wReady) begin
                wReady <= 1'b0;
                wGot <= 1'b1;
                wDataHold <= wData;
                strbAll <= strbAll & wStrb;
            end else if (wValid && !wGot) begin
                wReady <= chance();
            end
            if (awGot && wGot && !bValid && chance()) begin
                bValid <= 1'b1;
                awGot <= 1'b0;
                wGot <= 1'b0;
                mem[wAddrHold[11:2]] <= wDataHold;
                gotStores.push_back({wAddrHold, wDataHold});
            end
            if (bValid && bReady) bValid <= 1'b0;
        end
    end

    task check(input string testName, input string what, input logic [63:0] expected,
               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %h, actual %h", testName, what, expected, actual);
            errors++;
        end
    endtask

    task runTest(input string name, input int delay, input bit midReset);
        int errsBefore;
        int n;
        errsBefore = errors;
        maxDelay = delay;
        @(posedge clk);
        reset_n <= 1'b0;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        if (midReset) begin
            repeat (150) @(posedge clk);
            reset_n <= 1'b0;                       // Abort mid-program
            repeat (10) @(posedge clk);
            reset_n <= 1'b1;
        end
        while (gotStores.size() < expStores.size()) @(posedge clk);
        repeat (60) @(posedge clk);                // Room for extra writes to show
        check(name, "write count", 64'(expStores.size()), 64'(gotStores.size()));
        n = (gotStores.size() < expStores.size()) ? gotStores.size() : expStores.size();
        for (int i = 0; i < n; i++)
            check(name, (i >= expStores.size() - 15) ? $sformatf("final x%0d", i + 16 - n)
                  : $sformatf("store %0d", i), expStores[i], gotStores[i]);
        if (midReset) check(name, "first read address", 64'(`RV_RESET_PC), 64'(firstAr));
        check(name, "write strobes", 64'hF, 64'(strbAll));
        if (errors != errsBefore) failedTests++;
        $display("%s: %0d writes checked, %0d errors", name, n, errors - errsBefore);
    endtask

    initial begin
        genRandom();
        runModel();
        runTest("storeStream", 3, 1'b0);
        runTest("backPressure", 15, 1'b0);
        runTest("midRunReset", 3, 1'b1);
        genHazards();
        runModel();
        runTest("hazards", 3, 1'b0);
        $display("Tests: %0d, failed: %0d, errors: %0d", NUM_TESTS, failedTests, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // 200 cycles per instruction with 20 percent margin for every test
    initial begin
        repeat (NUM_TESTS * 200 * PROG_LEN * 12 / 10) @(posedge clk);
        $display("Timeout: the program did not finish writing its results");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* rvPipe_config.svh */
/*
 Core-wide constants. The decoder and immediate logic assume RV_XLEN is 32.
 RV_NOP is ADDI x0,x0,0 and fills the fetch register while it is empty.
*/
`ifndef RV_PIPE_CONFIG_SVH
`define RV_PIPE_CONFIG_SVH

`define RV_XLEN      32            // Data and address width
`define RV_REG_COUNT 32            // Architectural registers
`define RV_RESET_PC  32'h0000_0000 // First fetch address
`define RV_NOP       32'h0000_0013 // ADDI x0,x0,0

`endif
